//--- hw/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// ==================================================
// Register counts
// ==================================================

// Architectural registers seen by the ISA
`define ARCH_REGS 16

// Physical registers behind the rename map
// Must exceed ARCH_REGS by at least DISP_WIDTH
`define PHYS_REGS 32

// ==================================================
// Port counts
// ==================================================

// Rename slots per cycle
`define DISP_WIDTH 2

// Writeback ports marking tags ready
`define WB_WIDTH 2

// Commit ports updating the committed map
`define COMMIT_WIDTH 2

// Tag widths derived from the counts
`define ARCH_BITS $clog2(`ARCH_REGS)
`define PHYS_BITS $clog2(`PHYS_REGS)

`endif

//--- hw/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    // ==================================================
    // Register tags
    // ==================================================

    // Index of an architectural register
    typedef logic [`ARCH_BITS-1:0] arch_tag_t;

    // Tag of a physical register
    typedef logic [`PHYS_BITS-1:0] phys_tag_t;

    // ==================================================
    // Map table entry
    // ==================================================

    // One speculative mapping per architectural register
    // Ready is set once the producing instruction writes back
    typedef struct packed {
        phys_tag_t phys;
        logic      ready;
    } map_entry_t;

endpackage

//--- hw/map_table.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module map_table (
    input  logic                                        clock,
    input  logic                                        reset,

    // Rename of destination registers
    input  logic [`DISP_WIDTH-1:0]                      disp_grant_i,
    input  rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     disp_arch_i,
    input  rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_new_phys_i,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_old_phys_o,

    // Source operand lookup
    input  rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     rs1_arch_i,
    input  rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     rs2_arch_i,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     rs1_phys_o,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     rs2_phys_o,
    output logic [`DISP_WIDTH-1:0]                      rs1_ready_o,
    output logic [`DISP_WIDTH-1:0]                      rs2_ready_o,

    // Writeback of finished results
    input  logic [`WB_WIDTH-1:0]                        wb_valid_i,
    input  rename_pkg::phys_tag_t [`WB_WIDTH-1:0]       wb_phys_i,

    // Restore from the committed map
    input  logic                                        recover_i,
    input  rename_pkg::phys_tag_t [`ARCH_REGS-1:0]      committed_map_i
);

    // Speculative map, one entry per architectural register
    rename_pkg::map_entry_t map_q [`ARCH_REGS];
    rename_pkg::map_entry_t map_d [`ARCH_REGS];

    // ==================================================
    // Lookup with in-group bypass
    // ==================================================

    always_comb begin
        for (int i = 0; i < `DISP_WIDTH; i++) begin
            // Start from the table contents
            rs1_phys_o[i]      = map_q[rs1_arch_i[i]].phys;
            rs1_ready_o[i]     = map_q[rs1_arch_i[i]].ready;
            rs2_phys_o[i]      = map_q[rs2_arch_i[i]].phys;
            rs2_ready_o[i]     = map_q[rs2_arch_i[i]].ready;
            disp_old_phys_o[i] = map_q[disp_arch_i[i]].phys;

            // Older granted slots in this group rename first
            // The youngest matching older slot is applied last
            for (int j = 0; j < i; j++) begin
                if (disp_grant_i[j] && (disp_arch_i[j] == rs1_arch_i[i])) begin
                    rs1_phys_o[i]  = disp_new_phys_i[j];
                    rs1_ready_o[i] = 1'b0;
                end
                if (disp_grant_i[j] && (disp_arch_i[j] == rs2_arch_i[i])) begin
                    rs2_phys_o[i]  = disp_new_phys_i[j];
                    rs2_ready_o[i] = 1'b0;
                end
                // Old tag of a repeated destination is the older slot's new tag
                if (disp_grant_i[j] && (disp_arch_i[j] == disp_arch_i[i])) begin
                    disp_old_phys_o[i] = disp_new_phys_i[j];
                end
            end
        end
    end

    // ==================================================
    // Next-state table
    // ==================================================

    always_comb begin
        map_d = map_q;

        // Writeback marks every entry that still holds the tag
        for (int w = 0; w < `WB_WIDTH; w++) begin
            if (wb_valid_i[w]) begin
                for (int a = 0; a < `ARCH_REGS; a++) begin
                    if (map_q[a].phys == wb_phys_i[w]) begin
                        map_d[a].ready = 1'b1;
                    end
                end
            end
        end

        // Renames come after writeback so they win on the same entry
        // Slot order keeps the youngest rename of a register
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            if (disp_grant_i[s]) begin
                map_d[disp_arch_i[s]].phys  = disp_new_phys_i[s];
                map_d[disp_arch_i[s]].ready = 1'b0;
            end
        end

        // Recovery replaces the whole table, all values committed
        if (recover_i) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                map_d[a].phys  = committed_map_i[a];
                map_d[a].ready = 1'b1;
            end
        end
    end

    // Identity map after reset, every register ready
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                map_q[a].phys  <= rename_pkg::phys_tag_t'(a);
                map_q[a].ready <= 1'b1;
            end
        end else begin
            map_q <= map_d;
        end
    end

endmodule

//--- hw/free_list.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module free_list (
    input  logic                                        clock,
    input  logic                                        reset,

    // Allocation for dispatch
    input  logic [`DISP_WIDTH-1:0]                      disp_valid_i,
    input  logic                                        recover_i,
    output logic                                        disp_ready_o,
    output logic [`DISP_WIDTH-1:0]                      disp_grant_o,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_new_phys_o,

    // Old tags released at commit
    input  logic [`COMMIT_WIDTH-1:0]                    release_valid_i,
    input  rename_pkg::phys_tag_t [`COMMIT_WIDTH-1:0]   release_phys_i,

    // Committed map used to rebuild the free set
    input  rename_pkg::phys_tag_t [`ARCH_REGS-1:0]      committed_map_i
);

    localparam int CNT_BITS = $clog2(`PHYS_REGS + 1);

    // One bit per physical tag, set when free
    logic [`PHYS_REGS-1:0] free_q;
    logic [`PHYS_REGS-1:0] free_d;
    // Number of free tags, registered so ready comes straight from a flop
    logic [CNT_BITS-1:0]   count_q;
    logic [CNT_BITS-1:0]   count_d;

    // Candidates in ascending order
    logic [`PHYS_REGS-1:0]                      avail;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]    pick;

    // Priority encoder, lowest set bit wins
    function automatic rename_pkg::phys_tag_t lowest_free(input logic [`PHYS_REGS-1:0] vec);
        rename_pkg::phys_tag_t idx;
        idx = '0;
        for (int t = `PHYS_REGS - 1; t >= 0; t--) begin
            if (vec[t]) begin
                idx = rename_pkg::phys_tag_t'(t);
            end
        end
        return idx;
    endfunction

    function automatic logic [CNT_BITS-1:0] popcount(input logic [`PHYS_REGS-1:0] vec);
        logic [CNT_BITS-1:0] n;
        n = '0;
        for (int t = 0; t < `PHYS_REGS; t++) begin
            n = n + CNT_BITS'(vec[t]);
        end
        return n;
    endfunction

    // ==================================================
    // Allocation
    // ==================================================

    // Mask each pick before searching for the next one
    always_comb begin
        avail = free_q;
        for (int k = 0; k < `DISP_WIDTH; k++) begin
            pick[k]        = lowest_free(avail);
            avail[pick[k]] = 1'b0;
        end
    end

    // Full group or nothing
    assign disp_ready_o = (count_q >= CNT_BITS'(`DISP_WIDTH));
    assign disp_grant_o = (disp_ready_o && !recover_i) ? disp_valid_i : '0;

    // Lowest tag to the lowest granted slot
    always_comb begin
        int used;
        used = 0;
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            disp_new_phys_o[s] = pick[used];
            if (disp_grant_o[s]) begin
                used = used + 1;
            end
        end
    end

    // ==================================================
    // Free set update
    // ==================================================

    always_comb begin
        free_d = free_q;
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            if (disp_grant_o[s]) begin
                free_d[disp_new_phys_o[s]] = 1'b0;
            end
        end
        // Released tags are never among this cycle's picks
        for (int c = 0; c < `COMMIT_WIDTH; c++) begin
            if (release_valid_i[c]) begin
                free_d[release_phys_i[c]] = 1'b1;
            end
        end
        // Rebuild: everything the committed map does not hold is free
        if (recover_i) begin
            free_d = '1;
            for (int a = 0; a < `ARCH_REGS; a++) begin
                free_d[committed_map_i[a]] = 1'b0;
            end
        end
        count_d = popcount(free_d);
    end

    // Tags below ARCH_REGS start out as the identity map
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int t = 0; t < `PHYS_REGS; t++) begin
                free_q[t] <= (t >= `ARCH_REGS);
            end
            count_q <= CNT_BITS'(`PHYS_REGS - `ARCH_REGS);
        end else begin
            free_q  <= free_d;
            count_q <= count_d;
        end
    end

endmodule

//--- hw/arch_map.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module arch_map (
    input  logic                                        clock,
    input  logic                                        reset,

    // Commits, presented in program order
    input  logic [`COMMIT_WIDTH-1:0]                    commit_valid_i,
    input  rename_pkg::arch_tag_t [`COMMIT_WIDTH-1:0]   commit_arch_i,
    input  rename_pkg::phys_tag_t [`COMMIT_WIDTH-1:0]   commit_phys_i,

    // Commits are dropped during recovery
    input  logic                                        recover_i,

    // Committed state, restore image for recovery
    output rename_pkg::phys_tag_t [`ARCH_REGS-1:0]      committed_map_o
);

    // ==================================================
    // Committed map
    // ==================================================

    rename_pkg::phys_tag_t [`ARCH_REGS-1:0] map_q;

    // Slot order in the loop lets the younger commit win
    // when both slots name the same register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REGS; a++) begin
                map_q[a] <= rename_pkg::phys_tag_t'(a);
            end
        end else if (!recover_i) begin
            for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                if (commit_valid_i[c]) begin
                    map_q[commit_arch_i[c]] <= commit_phys_i[c];
                end
            end
        end
    end

    // Whole map goes to the map table and the free list
    assign committed_map_o = map_q;

endmodule

//--- hw/rename_top.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_top (
    input  logic                                        clock,
    input  logic                                        reset,

    // ==================================================
    // Dispatch
    // ==================================================
    input  logic [`DISP_WIDTH-1:0]                      disp_valid_i,
    input  rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     disp_arch_i,
    input  rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     rs1_arch_i,
    input  rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     rs2_arch_i,
    output logic                                        disp_ready_o,
    output logic [`DISP_WIDTH-1:0]                      disp_grant_o,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_new_phys_o,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_old_phys_o,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     rs1_phys_o,
    output logic [`DISP_WIDTH-1:0]                      rs1_ready_o,
    output rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     rs2_phys_o,
    output logic [`DISP_WIDTH-1:0]                      rs2_ready_o,

    // ==================================================
    // Writeback, commit and recovery
    // ==================================================
    input  logic [`WB_WIDTH-1:0]                        wb_valid_i,
    input  rename_pkg::phys_tag_t [`WB_WIDTH-1:0]       wb_phys_i,
    input  logic [`COMMIT_WIDTH-1:0]                    commit_valid_i,
    input  rename_pkg::arch_tag_t [`COMMIT_WIDTH-1:0]   commit_arch_i,
    input  rename_pkg::phys_tag_t [`COMMIT_WIDTH-1:0]   commit_phys_i,
    input  rename_pkg::phys_tag_t [`COMMIT_WIDTH-1:0]   commit_old_phys_i,
    input  logic                                        recover_i
);

    // Committed map shared by both recovery consumers
    rename_pkg::phys_tag_t [`ARCH_REGS-1:0] committed_map;

    // Grant and new tags from the free list drive the renames
    free_list u_free_list (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .recover_i       (recover_i),
        .disp_ready_o    (disp_ready_o),
        .disp_grant_o    (disp_grant_o),
        .disp_new_phys_o (disp_new_phys_o),
        .release_valid_i (commit_valid_i),
        .release_phys_i  (commit_old_phys_i),
        .committed_map_i (committed_map)
    );

    map_table u_map_table (
        .clock           (clock),
        .reset           (reset),
        .disp_grant_i    (disp_grant_o),
        .disp_arch_i     (disp_arch_i),
        .disp_new_phys_i (disp_new_phys_o),
        .disp_old_phys_o (disp_old_phys_o),
        .rs1_arch_i      (rs1_arch_i),
        .rs2_arch_i      (rs2_arch_i),
        .rs1_phys_o      (rs1_phys_o),
        .rs2_phys_o      (rs2_phys_o),
        .rs1_ready_o     (rs1_ready_o),
        .rs2_ready_o     (rs2_ready_o),
        .wb_valid_i      (wb_valid_i),
        .wb_phys_i       (wb_phys_i),
        .recover_i       (recover_i),
        .committed_map_i (committed_map)
    );

    arch_map u_arch_map (
        .clock           (clock),
        .reset           (reset),
        .commit_valid_i  (commit_valid_i),
        .commit_arch_i   (commit_arch_i),
        .commit_phys_i   (commit_phys_i),
        .recover_i       (recover_i),
        .committed_map_o (committed_map)
    );

endmodule

//--- test/rename_checker.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_checker (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        recover_i,
    input  logic                                        disp_ready_i,
    input  logic [`DISP_WIDTH-1:0]                      disp_grant_i,
    input  rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_new_phys_i
);

    // ==================================================
    // Grant rules
    // ==================================================

    // First edge out of reset sees an idle dispatch
    grant_idle_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (disp_grant_i == '0)
    ) else $error("dispatch granted on the first cycle after reset");

    // Two granted slots never share a physical tag
    new_tags_distinct: assert property (
        @(posedge clock) disable iff (reset)
        (&disp_grant_i) |-> (disp_new_phys_i[0] != disp_new_phys_i[1])
    ) else $error("both slots received the same physical tag");

    // Recovery blocks all renames
    no_grant_on_recover: assert property (
        @(posedge clock) disable iff (reset)
        recover_i |-> (disp_grant_i == '0)
    ) else $error("dispatch granted during recovery");

    // Grant only with enough free tags
    no_grant_when_busy: assert property (
        @(posedge clock) disable iff (reset)
        !disp_ready_i |-> (disp_grant_i == '0)
    ) else $error("dispatch granted while not ready");

endmodule

bind rename_top rename_checker u_checker (
    .clock           (clock),
    .reset           (reset),
    .recover_i       (recover_i),
    .disp_ready_i    (disp_ready_o),
    .disp_grant_i    (disp_grant_o),
    .disp_new_phys_i (disp_new_phys_o)
);

//--- test/rename_tb.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_tb;

    localparam int NUM_CYCLES  = 3000;
    localparam int STALL_LIMIT = 200;
    localparam int READY_LIMIT = 20;

    // One renamed instruction as the reorder buffer sees it
    typedef struct packed {
        rename_pkg::arch_tag_t arch;
        rename_pkg::phys_tag_t new_phys;
        rename_pkg::phys_tag_t old_phys;
        logic                  done;
    } rob_entry_t;

    logic clock;
    logic reset;

    logic [`DISP_WIDTH-1:0]                      disp_valid_i;
    rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     disp_arch_i;
    rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     rs1_arch_i;
    rename_pkg::arch_tag_t [`DISP_WIDTH-1:0]     rs2_arch_i;
    logic                                        disp_ready_o;
    logic [`DISP_WIDTH-1:0]                      disp_grant_o;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_new_phys_o;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     disp_old_phys_o;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     rs1_phys_o;
    logic [`DISP_WIDTH-1:0]                      rs1_ready_o;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0]     rs2_phys_o;
    logic [`DISP_WIDTH-1:0]                      rs2_ready_o;
    logic [`WB_WIDTH-1:0]                        wb_valid_i;
    rename_pkg::phys_tag_t [`WB_WIDTH-1:0]       wb_phys_i;
    logic [`COMMIT_WIDTH-1:0]                    commit_valid_i;
    rename_pkg::arch_tag_t [`COMMIT_WIDTH-1:0]   commit_arch_i;
    rename_pkg::phys_tag_t [`COMMIT_WIDTH-1:0]   commit_phys_i;
    rename_pkg::phys_tag_t [`COMMIT_WIDTH-1:0]   commit_old_phys_i;
    logic                                        recover_i;

    // ==================================================
    // Reference model state
    // ==================================================

    rename_pkg::map_entry_t spec_map [`ARCH_REGS];
    rename_pkg::phys_tag_t  commit_map [`ARCH_REGS];
    logic [`PHYS_REGS-1:0]  free_set;
    rob_entry_t             rob_q [$];

    // Expected dispatch results of the current cycle
    logic                                    exp_ready;
    logic [`DISP_WIDTH-1:0]                  exp_grant;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0] exp_new;
    rename_pkg::phys_tag_t [`DISP_WIDTH-1:0] exp_old;

    integer      seed;
    logic [31:0] rnd;

    rename_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("FAIL %s expected %0d actual %0d", name, expected, actual);
            $display("sim failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // Identity map with every entry ready and the upper tags free
    task automatic reset_model();
        for (int a = 0; a < `ARCH_REGS; a++) begin
            spec_map[a].phys  = rename_pkg::phys_tag_t'(a);
            spec_map[a].ready = 1'b1;
            commit_map[a]     = rename_pkg::phys_tag_t'(a);
        end
        for (int t = 0; t < `PHYS_REGS; t++) begin
            free_set[t] = (t >= `ARCH_REGS);
        end
        rob_q.delete();
    endtask

    task automatic clear_inputs();
        disp_valid_i      = '0;
        disp_arch_i       = '0;
        rs1_arch_i        = '0;
        rs2_arch_i        = '0;
        wb_valid_i        = '0;
        wb_phys_i         = '0;
        commit_valid_i    = '0;
        commit_arch_i     = '0;
        commit_phys_i     = '0;
        commit_old_phys_i = '0;
        recover_i         = 1'b0;
    endtask

    task automatic wait_for_ready(input int limit);
        int waited;
        waited = 0;
        while (!disp_ready_o) begin
            if (waited >= limit) begin
                $display("sim failed");
                $fatal(1, "dispatch never became ready after reset");
            end
            @(posedge clock);
            #1;
            waited++;
        end
    endtask

    // Every register maps to itself and is ready
    task automatic check_identity();
        for (int k = 0; k < `ARCH_REGS / 2; k++) begin
            rs1_arch_i[0] = rename_pkg::arch_tag_t'(2 * k);
            rs1_arch_i[1] = rename_pkg::arch_tag_t'(2 * k + 1);
            rs2_arch_i[0] = rename_pkg::arch_tag_t'(`ARCH_REGS - 1 - 2 * k);
            rs2_arch_i[1] = rename_pkg::arch_tag_t'(`ARCH_REGS - 2 - 2 * k);
            #1;
            check("reset ready", 1, int'(disp_ready_o));
            for (int s = 0; s < `DISP_WIDTH; s++) begin
                check("reset rs1 tag", int'(rs1_arch_i[s]), int'(rs1_phys_o[s]));
                check("reset rs1 ready", 1, int'(rs1_ready_o[s]));
                check("reset rs2 tag", int'(rs2_arch_i[s]), int'(rs2_phys_o[s]));
                check("reset rs2 ready", 1, int'(rs2_ready_o[s]));
            end
            @(posedge clock);
            #1;
        end
    endtask

    // Source as the model sees it including the bypass from slot 0
    function automatic rename_pkg::map_entry_t expect_source(input int slot,
                                                             input rename_pkg::arch_tag_t arch);
        rename_pkg::map_entry_t e;
        e = spec_map[arch];
        if (slot == 1 && exp_grant[0] && disp_arch_i[0] == arch) begin
            e.phys  = exp_new[0];
            e.ready = 1'b0;
        end
        return e;
    endfunction

    // ==================================================
    // Expected outputs from the model
    // ==================================================

    task automatic compute_expected();
        rename_pkg::phys_tag_t lowest [2];
        int free_cnt;
        int n_low;
        int used;
        free_cnt = 0;
        n_low    = 0;
        lowest[0] = '0;
        lowest[1] = '0;
        for (int t = 0; t < `PHYS_REGS; t++) begin
            if (free_set[t]) begin
                free_cnt++;
                if (n_low < 2) begin
                    lowest[n_low] = rename_pkg::phys_tag_t'(t);
                    n_low++;
                end
            end
        end
        exp_ready = (free_cnt >= 2);
        exp_grant = (exp_ready && !recover_i) ? disp_valid_i : '0;
        // Lowest free tag goes to the lowest granted slot
        used    = 0;
        exp_new = '0;
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            if (exp_grant[s]) begin
                exp_new[s] = lowest[used];
                used++;
            end
        end
        exp_old[0] = spec_map[disp_arch_i[0]].phys;
        exp_old[1] = spec_map[disp_arch_i[1]].phys;
        if (exp_grant[0] && disp_arch_i[0] == disp_arch_i[1]) begin
            exp_old[1] = exp_new[0];
        end
    endtask

    task automatic check_outputs();
        rename_pkg::map_entry_t e;
        check("disp_ready", int'(exp_ready), int'(disp_ready_o));
        check("disp_grant", int'(exp_grant), int'(disp_grant_o));
        for (int s = 0; s < `DISP_WIDTH; s++) begin
            if (exp_grant[s]) begin
                check($sformatf("new tag slot %0d", s), int'(exp_new[s]),
                      int'(disp_new_phys_o[s]));
            end
            check($sformatf("old tag slot %0d", s), int'(exp_old[s]), int'(disp_old_phys_o[s]));
            e = expect_source(s, rs1_arch_i[s]);
            check($sformatf("rs1 tag slot %0d", s), int'(e.phys), int'(rs1_phys_o[s]));
            check($sformatf("rs1 ready slot %0d", s), int'(e.ready), int'(rs1_ready_o[s]));
            e = expect_source(s, rs2_arch_i[s]);
            check($sformatf("rs2 tag slot %0d", s), int'(e.phys), int'(rs2_phys_o[s]));
            check($sformatf("rs2 ready slot %0d", s), int'(e.ready), int'(rs2_ready_o[s]));
        end
    endtask

    // ==================================================
    // Random traffic acting as the reorder buffer
    // ==================================================

    task automatic run_random(input int cycles);
        int         pending [$];
        int         wb_idx [`WB_WIDTH];
        int         pick;
        int         stall;
        logic       in_order;
        rob_entry_t entry;
        stall = 0;
        for (int cyc = 0; cyc < cycles; cyc++) begin
            clear_inputs();
            rnd = $random(seed);
            recover_i = (cyc > 10) && ((int'(rnd[15:0]) % 40) == 0);
            rnd = $random(seed);
            disp_valid_i  = rnd[1:0];
            disp_arch_i   = rnd[9:2];
            rs1_arch_i    = rnd[17:10];
            rs2_arch_i    = rnd[25:18];
            rnd = $random(seed);
            // Commit only done entries contiguous from the head
            // Commits and writebacks keep arriving during recovery and must be dropped
            in_order = 1'b1;
            for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                if (in_order && rob_q.size() > c && rob_q[c].done && rnd[c]) begin
                    commit_valid_i[c]    = 1'b1;
                    commit_arch_i[c]     = rob_q[c].arch;
                    commit_phys_i[c]     = rob_q[c].new_phys;
                    commit_old_phys_i[c] = rob_q[c].old_phys;
                end else begin
                    in_order = 1'b0;
                end
            end
            // Writeback picks distinct outstanding tags
            pending.delete();
            for (int i = 0; i < rob_q.size(); i++) begin
                if (!rob_q[i].done) begin
                    pending.push_back(i);
                end
            end
            for (int w = 0; w < `WB_WIDTH; w++) begin
                wb_idx[w] = 0;
                if (pending.size() > 0 && rnd[2 + w]) begin
                    pick         = int'(rnd[31:16]) % pending.size();
                    wb_idx[w]    = pending[pick];
                    wb_valid_i[w] = 1'b1;
                    wb_phys_i[w] = rob_q[pending[pick]].new_phys;
                    pending.delete(pick);
                end
            end
            #1;
            compute_expected();
            check_outputs();
            if (exp_ready) begin
                stall = 0;
            end else begin
                stall++;
            end
            if (stall > STALL_LIMIT) begin
                $display("sim failed");
                $fatal(1, "dispatch stayed blocked with no free tags");
            end
            // Advance the model to the state after this edge
            if (recover_i) begin
                free_set = '1;
                for (int a = 0; a < `ARCH_REGS; a++) begin
                    spec_map[a].phys  = commit_map[a];
                    spec_map[a].ready = 1'b1;
                    free_set[commit_map[a]] = 1'b0;
                end
                rob_q.delete();
            end else begin
                for (int w = 0; w < `WB_WIDTH; w++) begin
                    if (wb_valid_i[w]) begin
                        for (int a = 0; a < `ARCH_REGS; a++) begin
                            if (spec_map[a].phys == wb_phys_i[w]) begin
                                spec_map[a].ready = 1'b1;
                            end
                        end
                        entry = rob_q[wb_idx[w]];
                        entry.done = 1'b1;
                        rob_q[wb_idx[w]] = entry;
                    end
                end
                for (int c = 0; c < `COMMIT_WIDTH; c++) begin
                    if (commit_valid_i[c]) begin
                        commit_map[commit_arch_i[c]] = commit_phys_i[c];
                        free_set[commit_old_phys_i[c]] = 1'b1;
                        void'(rob_q.pop_front());
                    end
                end
                // Renames go last so they beat a same-cycle writeback
                for (int s = 0; s < `DISP_WIDTH; s++) begin
                    if (exp_grant[s]) begin
                        free_set[exp_new[s]] = 1'b0;
                        entry.arch     = disp_arch_i[s];
                        entry.new_phys = exp_new[s];
                        entry.old_phys = exp_old[s];
                        entry.done     = 1'b0;
                        rob_q.push_back(entry);
                        spec_map[disp_arch_i[s]].phys  = exp_new[s];
                        spec_map[disp_arch_i[s]].ready = 1'b0;
                    end
                end
            end
            @(posedge clock);
            #1;
        end
    endtask

    initial begin
        seed  = 50179;
        reset = 1'b1;
        clear_inputs();
        reset_model();
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        wait_for_ready(READY_LIMIT);
        check_identity();
        run_random(NUM_CYCLES);
        $display("sim passed");
        $finish;
    end

endmodule

//--- vlog.f
+incdir+hw
hw/rename_pkg.sv
hw/map_table.sv
hw/free_list.sv
hw/arch_map.sv
hw/rename_top.sv
test/rename_checker.sv
test/rename_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the rename testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rename_tb \
    -f vlog.f \
    -o rename_sim

./obj_dir/rename_sim
